// ==== filelist.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/frontend_pkg.sv
rtl/icache.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/slot_pair_reg.sv
rtl/dispatch_ctrl.sv
rtl/frontend_top.sv
testbench/tb_frontend.sv

// ==== rtl/decoder.sv ====
// Pure combinational decode of one word; the slot valid bit is carried outside this block
`timescale 1ns/1ps
`include "frontend_cfg.svh"

module decoder (
  input  logic [`FE_INST_WIDTH-1:0] ir,
  output isa_pkg::decoded_t         decoded
);

  isa_pkg::opcode_e opcode;
  logic [6:0]       oper_fn;
  logic             fn_known;

  assign opcode  = isa_pkg::opcode_e'(ir[31:26]);
  assign oper_fn = ir[11:5];

  always_comb begin
    decoded          = '0;
    fn_known         = 1'b0;
    decoded.rega_idx = ir[25:21];
    decoded.regb_idx = ir[20:16];
    decoded.dest_idx = 5'(`FE_ZERO_REG);   // No write unless set below
    decoded.alu_func = isa_pkg::ALU_ADD;

    case (opcode)
      isa_pkg::OP_PAL: begin
        if (ir[25:0] == isa_pkg::PAL_HALT_CODE) decoded.halt = 1'b1;
        else decoded.illegal = 1'b1;   // Any other PAL call
      end
      isa_pkg::OP_OPER: begin
        decoded.dest_idx = ir[4:0];
        for (int i = 0; i < isa_pkg::ALU_FUNCS; i++) begin
          if (oper_fn == isa_pkg::OPER_FN_TABLE[i]) begin
            fn_known         = 1'b1;
            decoded.alu_func = isa_pkg::alu_func_e'(3'(i));
          end
        end
        decoded.illegal = !fn_known;
      end
      isa_pkg::OP_LDQ: begin
        decoded.dest_idx = ir[25:21];
        decoded.rd_mem   = 1'b1;
      end
      isa_pkg::OP_STQ: decoded.wr_mem = 1'b1;
      isa_pkg::OP_BR: begin
        decoded.dest_idx      = ir[25:21];   // Link register
        decoded.uncond_branch = 1'b1;
      end
      isa_pkg::OP_BEQ: decoded.cond_branch = 1'b1;
      default: decoded.illegal = 1'b1;
    endcase
  end

endmodule

// ==== rtl/dispatch_ctrl.sv ====
// Back end takes slots in order; dispatch_free of 3 is treated as 2, error status is sticky until reset
`timescale 1ns/1ps

module dispatch_ctrl (
  input  logic                         clock,
  input  logic                         reset,
  input  frontend_pkg::dispatch_slot_t slots [2],
  input  logic [1:0]                   dispatch_free,
  input  logic                         redirect_valid,
  output logic                         dp_load,
  output logic                         dp_shift,
  output logic                         if_load,
  output logic                         flush,
  output isa_pkg::error_status_e       error_status
);

  logic accept0;
  logic accept1;

  assign accept0 = slots[0].valid && (dispatch_free >= 2'd1);
  assign accept1 = slots[1].valid && (dispatch_free >= 2'd2);

  ////////////////////
  // Register controls
  assign dp_load  = (!slots[0].valid || accept0) && (!slots[1].valid || accept1);
  assign dp_shift = accept0 && slots[1].valid && !accept1;   // Partial acceptance
  assign if_load  = dp_load;
  assign flush    = redirect_valid;

  // First accepted halt or illegal wins, slot 0 first
  always_ff @(posedge clock) begin
    if (reset) begin
      error_status <= isa_pkg::NO_ERROR;
    end else if (error_status == isa_pkg::NO_ERROR) begin
      if (accept0 && slots[0].dec.illegal) begin
        error_status <= isa_pkg::HALTED_ON_ILLEGAL;
      end else if (accept0 && slots[0].dec.halt) begin
        error_status <= isa_pkg::HALTED_ON_HALT;
      end else if (accept1 && slots[1].dec.illegal) begin
        error_status <= isa_pkg::HALTED_ON_ILLEGAL;
      end else if (accept1 && slots[1].dec.halt) begin
        error_status <= isa_pkg::HALTED_ON_HALT;
      end
    end
  end

endmodule

// ==== rtl/fetch_unit.sv ====
// PC is kept line aligned, so redirect targets must be 8-byte aligned; no branch prediction
`timescale 1ns/1ps
`include "frontend_cfg.svh"

module fetch_unit (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      advance,
  input  logic                      redirect_valid,
  input  logic [`FE_ADDR_WIDTH-1:0] redirect_pc,
  input  logic                      hit,
  input  logic [`FE_LINE_WIDTH-1:0] line_data,
  output logic [`FE_ADDR_WIDTH-1:0] fetch_addr,
  output logic                      fetch_req,
  output frontend_pkg::fetch_slot_t fetch_pair [2]
);

  localparam int OFFSET_W = $clog2(`FE_LINE_WIDTH / 8);
  localparam logic [`FE_ADDR_WIDTH-1:0] INST_STEP = `FE_INST_WIDTH / 8;
  localparam logic [`FE_ADDR_WIDTH-1:0] LINE_STEP = `FE_LINE_WIDTH / 8;

  logic [`FE_ADDR_WIDTH-1:0] pc;
  logic [`FE_ADDR_WIDTH-1:0] line_pc;

  assign line_pc    = {pc[`FE_ADDR_WIDTH-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign fetch_addr = line_pc;
  assign fetch_req  = !redirect_valid;   // Old path is dropped on redirect

  // Split the line, lower word first
  always_comb begin
    fetch_pair[0].npc   = line_pc + INST_STEP;
    fetch_pair[0].ir    = line_data[`FE_INST_WIDTH-1:0];
    fetch_pair[0].valid = hit;
    fetch_pair[1].npc   = line_pc + LINE_STEP;
    fetch_pair[1].ir    = line_data[`FE_LINE_WIDTH-1 -: `FE_INST_WIDTH];
    fetch_pair[1].valid = hit;
  end

  ////////////////////
  // Program counter
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= `FE_RESET_PC;
    end else if (redirect_valid) begin
      pc <= redirect_pc;
    end else if (advance && hit) begin   // IF/ID took a valid pair
      pc <= line_pc + LINE_STEP;
    end
  end

endmodule

// ==== rtl/frontend_cfg.svh ====
// Widths are fixed for a 32-bit, two-wide front end with 64-bit cache lines; other values are untested
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

////////////////////
// Datapath widths
`define FE_ADDR_WIDTH  32   // Byte address
`define FE_INST_WIDTH  32
`define FE_LINE_WIDTH  64   // Two instructions per line

////////////////////
// Instruction cache
`define FE_CACHE_LINES 32   // Power of two

////////////////////
// Reset values
`define FE_ZERO_REG    31
`define FE_NOOP_INST   32'h43ff_041f  // ADD r31, r31 -> r31
`define FE_RESET_PC    32'h0000_0000

`endif

// ==== rtl/frontend_pkg.sv ====
// Slot types assume one fetch pair per cache line; the Wishbone request is read-only, no we or sel
`include "frontend_cfg.svh"

package frontend_pkg;

  ////////////////////
  // Pipeline slots
  typedef struct packed {
    logic [`FE_ADDR_WIDTH-1:0] npc;   // Address of the next instruction
    logic [`FE_INST_WIDTH-1:0] ir;
    logic                      valid;
  } fetch_slot_t;

  typedef struct packed {
    logic [`FE_ADDR_WIDTH-1:0] npc;
    logic [`FE_INST_WIDTH-1:0] ir;
    isa_pkg::decoded_t         dec;
    logic                      valid;
  } dispatch_slot_t;

  ////////////////////
  // Wishbone classic read request
  typedef struct packed {
    logic                      cyc;
    logic                      stb;   // Same as cyc, single transfers only
    logic [`FE_ADDR_WIDTH-1:0] adr;   // Always line aligned
  } wb_req_t;

endpackage

// ==== rtl/frontend_top.sv ====
// Front end only; the back end drives dispatch_free and redirects, memory is a Wishbone read slave
`timescale 1ns/1ps
`include "frontend_cfg.svh"

module frontend_top (
  input  logic                         clock,
  input  logic                         reset,
  output frontend_pkg::wb_req_t        wb_req,
  input  logic [`FE_LINE_WIDTH-1:0]    wb_dat_i,
  input  logic                         wb_ack,
  input  logic [1:0]                   dispatch_free,
  input  logic                         redirect_valid,
  input  logic [`FE_ADDR_WIDTH-1:0]    redirect_pc,
  output frontend_pkg::dispatch_slot_t dispatch_slots [2],
  output isa_pkg::error_status_e       error_status
);

  logic [`FE_ADDR_WIDTH-1:0]    fetch_addr;
  logic                         fetch_req;
  logic                         hit;
  logic [`FE_LINE_WIDTH-1:0]    line_data;
  frontend_pkg::fetch_slot_t    fetch_pair [2];
  frontend_pkg::fetch_slot_t    if_id [2];
  isa_pkg::decoded_t            id_dec [2];
  frontend_pkg::dispatch_slot_t id_dp_din [2];
  logic                         dp_load;
  logic                         dp_shift;
  logic                         if_load;
  logic                         flush;

  ////////////////////
  // Fetch
  icache u_icache (
    .clock, .reset, .fetch_addr, .fetch_req, .hit, .line_data,
    .wb_req, .wb_dat_i, .wb_ack
  );

  fetch_unit u_fetch (
    .clock, .reset, .advance(if_load), .redirect_valid, .redirect_pc,
    .hit, .line_data, .fetch_addr, .fetch_req, .fetch_pair
  );

  slot_pair_reg #(.slot_t(frontend_pkg::fetch_slot_t)) u_if_id (
    .clock, .reset, .load(if_load), .shift(1'b0), .flush,
    .din(fetch_pair), .dout(if_id)
  );

  ////////////////////
  // Decode, one per slot
  for (genvar s = 0; s < 2; s++) begin : g_decode
    decoder u_decoder (.ir(if_id[s].ir), .decoded(id_dec[s]));

    assign id_dp_din[s].npc   = if_id[s].npc;
    assign id_dp_din[s].ir    = if_id[s].ir;
    assign id_dp_din[s].dec   = id_dec[s];
    assign id_dp_din[s].valid = if_id[s].valid;
  end

  ////////////////////
  // Dispatch
  slot_pair_reg #(.slot_t(frontend_pkg::dispatch_slot_t)) u_id_dp (
    .clock, .reset, .load(dp_load), .shift(dp_shift), .flush,
    .din(id_dp_din), .dout(dispatch_slots)
  );

  dispatch_ctrl u_dispatch_ctrl (
    .clock, .reset, .slots(dispatch_slots), .dispatch_free, .redirect_valid,
    .dp_load, .dp_shift, .if_load, .flush, .error_status
  );

endmodule

// ==== rtl/icache.sv ====
// Direct mapped and read only; one Wishbone read in flight, a fill is never aborted by a redirect
`timescale 1ns/1ps
`include "frontend_cfg.svh"

module icache (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [`FE_ADDR_WIDTH-1:0] fetch_addr,
  input  logic                      fetch_req,
  output logic                      hit,
  output logic [`FE_LINE_WIDTH-1:0] line_data,
  output frontend_pkg::wb_req_t     wb_req,
  input  logic [`FE_LINE_WIDTH-1:0] wb_dat_i,
  input  logic                      wb_ack
);

  localparam int OFFSET_W = $clog2(`FE_LINE_WIDTH / 8);
  localparam int INDEX_W  = $clog2(`FE_CACHE_LINES);
  localparam int TAG_W    = `FE_ADDR_WIDTH - INDEX_W - OFFSET_W;

  typedef enum logic {s_idle, s_busy} fill_state_e;

  logic                      line_valid [`FE_CACHE_LINES];
  logic [TAG_W-1:0]          tag_mem    [`FE_CACHE_LINES];
  logic [`FE_LINE_WIDTH-1:0] data_mem   [`FE_CACHE_LINES];

  fill_state_e               state;
  logic [`FE_ADDR_WIDTH-1:0] fill_addr;   // Line being fetched
  logic                      fill_done;
  logic [INDEX_W-1:0]        rd_index;
  logic [TAG_W-1:0]          rd_tag;
  logic [INDEX_W-1:0]        fill_index;
  logic [TAG_W-1:0]          fill_tag;

  assign rd_index   = fetch_addr[OFFSET_W +: INDEX_W];
  assign rd_tag     = fetch_addr[`FE_ADDR_WIDTH-1 -: TAG_W];
  assign fill_index = fill_addr[OFFSET_W +: INDEX_W];
  assign fill_tag   = fill_addr[`FE_ADDR_WIDTH-1 -: TAG_W];
  assign fill_done  = (state == s_busy) && wb_ack;

  ////////////////////
  // Lookup, same cycle
  assign hit       = fetch_req && line_valid[rd_index] && (tag_mem[rd_index] == rd_tag);
  assign line_data = data_mem[rd_index];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `FE_CACHE_LINES; i++) begin
        line_valid[i] <= 1'b0;
      end
    end else if (fill_done) begin
      line_valid[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fill_done) begin
      tag_mem[fill_index]  <= fill_tag;
      data_mem[fill_index] <= wb_dat_i;   // Sampled on the ack edge
    end
  end

  ////////////////////
  // Miss handling
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle: if (fetch_req && !hit) state <= s_busy;
        s_busy: if (wb_ack) state <= s_idle;   // cyc drops the cycle after ack
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == s_idle && fetch_req && !hit) begin
      fill_addr <= {fetch_addr[`FE_ADDR_WIDTH-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end
  end

  always_comb begin
    wb_req.cyc = (state == s_busy);
    wb_req.stb = (state == s_busy);
    wb_req.adr = fill_addr;
  end

endmodule

// ==== rtl/isa_pkg.sv ====
// Covers only a small Alpha-like subset; every encoding outside these tables decodes as illegal
package isa_pkg;

  ////////////////////
  // Opcodes, bits 31:26
  typedef enum logic [5:0] {
    OP_PAL  = 6'h00,
    OP_OPER = 6'h10,
    OP_LDQ  = 6'h29,
    OP_STQ  = 6'h2d,
    OP_BR   = 6'h30,
    OP_BEQ  = 6'h39
  } opcode_e;

  // Only PAL function recognised
  localparam logic [25:0] PAL_HALT_CODE = 26'h000_0555;

  ////////////////////
  // ALU functions
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,  // Also the address add
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5
  } alu_func_e;

  localparam int ALU_FUNCS = 6;

  // Operate function field (bits 11:5), indexed by alu_func_e
  localparam logic [6:0] OPER_FN_TABLE [ALU_FUNCS] = '{
    7'h20,  // ALU_ADD
    7'h29,  // ALU_SUB
    7'h00,  // ALU_AND
    7'h08,  // ALU_OR
    7'h40,  // ALU_XOR
    7'h39   // ALU_SLL
  };

  typedef enum logic [1:0] {
    NO_ERROR          = 2'd0,
    HALTED_ON_HALT    = 2'd1,
    HALTED_ON_ILLEGAL = 2'd2
  } error_status_e;

  typedef logic [4:0] reg_idx_t;

  // 24 bits of control for one instruction
  typedef struct packed {
    reg_idx_t  rega_idx;
    reg_idx_t  regb_idx;
    reg_idx_t  dest_idx;
    alu_func_e alu_func;
    logic      rd_mem;
    logic      wr_mem;
    logic      cond_branch;
    logic      uncond_branch;
    logic      halt;
    logic      illegal;
  } decoded_t;

endpackage

// ==== rtl/slot_pair_reg.sv ====
// slot_t must be a struct with ir and valid fields; only those two are cleared on reset or flush
`timescale 1ns/1ps
`include "frontend_cfg.svh"

module slot_pair_reg #(
  parameter type slot_t = frontend_pkg::fetch_slot_t
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  load,
  input  logic  shift,
  input  logic  flush,
  input  slot_t din  [2],
  output slot_t dout [2]
);

  always_ff @(posedge clock) begin
    if (reset || flush) begin   // Flush beats load
      for (int i = 0; i < 2; i++) begin
        dout[i].valid <= 1'b0;
        dout[i].ir    <= `FE_NOOP_INST;
      end
    end else if (load) begin
      dout[0] <= din[0];
      dout[1] <= din[1];
    end else if (shift) begin
      // Slot 0 left, slot 1 moves down
      dout[0]       <= dout[1];
      dout[1].valid <= 1'b0;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the front-end testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_frontend -f filelist.f -o tb_frontend_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/tb_frontend_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== testbench/tb_frontend.sv ====
// Memory image is 1 KB and wraps; redirects go to 8-byte aligned targets below 4 KB while dispatch_free is 0
`timescale 1ns/1ps
`include "frontend_cfg.svh"

module tb_frontend;

  localparam int RUN_CYCLES     = 3000;
  localparam int TIMEOUT_CYCLES = RUN_CYCLES + 1000;   // Reset and drain margin
  localparam int INDEX_W        = $clog2(`FE_CACHE_LINES);
  localparam int TAG_W          = `FE_ADDR_WIDTH - INDEX_W - 3;
  localparam logic [31:0] LFSR_MASK = 32'h8020_0003;
  localparam logic [25:0] HALT_CODE = 26'h000_0555;
  // Operate function codes indexed by ALU function
  localparam logic [6:0] FN_TABLE [6] = '{7'h20, 7'h29, 7'h00, 7'h08, 7'h40, 7'h39};
  localparam logic [5:0] OPCODES [5]  = '{6'h10, 6'h29, 6'h2d, 6'h30, 6'h39};

  logic                         clock;
  logic                         reset;
  frontend_pkg::wb_req_t        wb_req;
  logic [`FE_LINE_WIDTH-1:0]    wb_dat_i;
  logic                         wb_ack;
  logic [1:0]                   dispatch_free;
  logic                         redirect_valid;
  logic [`FE_ADDR_WIDTH-1:0]    redirect_pc;
  frontend_pkg::dispatch_slot_t dispatch_slots [2];
  isa_pkg::error_status_e       error_status;

  ////////////////////
  // Model state
  logic [31:0]                  lfsr;
  logic [31:0]                  mem [256];
  logic                         tag_valid [`FE_CACHE_LINES];
  logic [TAG_W-1:0]             tag_copy [`FE_CACHE_LINES];
  logic [31:0]                  exp_pc;   // Address of the next instruction to dispatch
  isa_pkg::error_status_e       exp_status;
  frontend_pkg::dispatch_slot_t prev_slots [2];
  logic                         prev_hold;
  logic                         prev_redirect;
  logic                         in_transfer;
  logic [1:0]                   wait_left;
  int                           errors;
  int                           accepted;
  int                           bus_reads;
  int                           cycle_count = 0;

  frontend_top u_dut (
    .clock, .reset, .wb_req, .wb_dat_i, .wb_ack, .dispatch_free,
    .redirect_valid, .redirect_pc, .dispatch_slots, .error_status
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        out_bit;
    value = '0;
    for (int i = 0; i < n; i++) begin
      out_bit = lfsr[0];
      lfsr    = (lfsr >> 1) ^ (out_bit ? LFSR_MASK : 32'h0);
      value   = {value[30:0], out_bit};
    end
    return value;
  endfunction

  function automatic logic [31:0] make_word();
    logic [3:0]  kind;
    logic [2:0]  op_sel;
    logic [2:0]  fn_sel;
    logic [31:0] word;
    kind   = 4'(rand_bits(4));
    op_sel = 3'(rand_bits(3));
    fn_sel = 3'(rand_bits(3));
    word   = rand_bits(32);
    if (kind == 4'd0) begin
      word = {6'h00, HALT_CODE};
    end else if (kind == 4'd1) begin
      word[31:26] = 6'h3f;   // Unknown opcode
    end else begin
      word[31:26] = OPCODES[int'(op_sel) % 5];
      if (word[31:26] == 6'h10 && fn_sel < 3'd6) word[11:5] = FN_TABLE[fn_sel];
    end
    return word;
  endfunction

  function automatic isa_pkg::decoded_t expected_decode(input logic [31:0] ir);
    isa_pkg::decoded_t d;
    d          = '0;
    d.rega_idx = ir[25:21];
    d.regb_idx = ir[20:16];
    d.dest_idx = 5'(`FE_ZERO_REG);
    d.alu_func = isa_pkg::ALU_ADD;
    case (ir[31:26])
      6'h00: begin
        d.halt    = (ir[25:0] == HALT_CODE);
        d.illegal = (ir[25:0] != HALT_CODE);
      end
      6'h10: begin
        d.dest_idx = ir[4:0];
        d.illegal  = 1'b1;
        for (int i = 0; i < 6; i++) begin
          if (ir[11:5] == FN_TABLE[i]) begin
            d.illegal  = 1'b0;
            d.alu_func = isa_pkg::alu_func_e'(3'(i));
          end
        end
      end
      6'h29: begin
        d.dest_idx = ir[25:21];
        d.rd_mem   = 1'b1;
      end
      6'h2d: d.wr_mem = 1'b1;
      6'h30: begin
        d.dest_idx      = ir[25:21];   // Link register
        d.uncond_branch = 1'b1;
      end
      6'h39: d.cond_branch = 1'b1;
      default: d.illegal = 1'b1;
    endcase
    return d;
  endfunction

  task automatic check_slot(input int k);
    logic [31:0]       exp_ir;
    isa_pkg::decoded_t exp_dec;
    exp_ir  = mem[exp_pc[9:2]];
    exp_dec = expected_decode(exp_ir);
    if (dispatch_slots[k].ir !== exp_ir) begin
      errors++;
      $display("CHECK FAILED slot%0d ir at pc %h: got %h, expected %h",
               k, exp_pc, dispatch_slots[k].ir, exp_ir);
    end
    if (dispatch_slots[k].npc !== exp_pc + 32'd4) begin
      errors++;
      $display("CHECK FAILED slot%0d npc: got %h, expected %h",
               k, dispatch_slots[k].npc, exp_pc + 32'd4);
    end
    if (dispatch_slots[k].dec !== exp_dec) begin
      errors++;
      $display("CHECK FAILED slot%0d dec: got %h, expected %h", k, dispatch_slots[k].dec, exp_dec);
    end
    if (exp_status == isa_pkg::NO_ERROR) begin
      if (exp_dec.illegal) exp_status = isa_pkg::HALTED_ON_ILLEGAL;
      else if (exp_dec.halt) exp_status = isa_pkg::HALTED_ON_HALT;
    end
    exp_pc = exp_pc + 32'd4;
    accepted++;
  endtask

  ////////////////////
  // Wishbone memory
  task automatic respond_bus();
    logic [INDEX_W-1:0] idx;
    logic [7:0]         word_idx;
    idx      = wb_req.adr[3 +: INDEX_W];
    word_idx = wb_req.adr[9:2];
    if (wb_req.stb !== wb_req.cyc) begin   // Single transfers, stb follows cyc
      errors++;
      $display("CHECK FAILED wb_req.stb: got %h, expected %h", wb_req.stb, wb_req.cyc);
    end
    if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (!in_transfer) begin   // New request
        in_transfer = 1'b1;
        bus_reads++;
        wait_left = 2'(rand_bits(2));
        if (wb_req.adr[2:0] != 3'b000 ||
            (tag_valid[idx] && tag_copy[idx] == wb_req.adr[31 -: TAG_W])) begin
          errors++;
          $display("Wishbone read of %h is unaligned or already resident", wb_req.adr);
        end
      end
      if (wait_left == 2'd0) begin
        wb_dat_i       = {mem[word_idx + 8'd1], mem[word_idx]};
        wb_ack         = 1'b1;
        in_transfer    = 1'b0;
        tag_valid[idx] = 1'b1;
        tag_copy[idx]  = wb_req.adr[31 -: TAG_W];
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end
  endtask

  task automatic step_cycle();
    logic [31:0] draw;
    respond_bus();
    if (error_status !== exp_status) begin
      errors++;
      $display("CHECK FAILED error_status: got %h, expected %h", error_status, exp_status);
    end
    if (prev_redirect && (dispatch_slots[0].valid || dispatch_slots[1].valid)) begin
      errors++;
      $display("A dispatch slot is still valid in the cycle after a redirect");
    end
    for (int k = 0; k < 2; k++) begin
      if (prev_hold && dispatch_slots[k] !== prev_slots[k]) begin
        errors++;
        $display("CHECK FAILED dispatch_slots[%0d] under stall: got %h, expected %h",
                 k, dispatch_slots[k], prev_slots[k]);
      end
    end
    draw           = rand_bits(2);
    dispatch_free  = (draw[1:0] == 2'd3) ? 2'd2 : draw[1:0];
    redirect_valid = 1'b0;
    if (dispatch_free == 2'd0) begin
      redirect_valid = (rand_bits(4) == 32'd0);   // About 1 in 64 cycles
      if (redirect_valid) begin
        draw        = rand_bits(9);
        redirect_pc = {{(`FE_ADDR_WIDTH-12){1'b0}}, draw[8:0], 3'b000};
      end
    end
    // Slots are stable until the next rising edge
    if (dispatch_slots[0].valid && dispatch_free >= 2'd1) check_slot(0);
    if (dispatch_slots[1].valid && dispatch_free == 2'd2) check_slot(1);
    if (redirect_valid) exp_pc = redirect_pc;
    prev_hold     = (dispatch_free == 2'd0) && !redirect_valid && dispatch_slots[0].valid;
    prev_redirect = redirect_valid;
    prev_slots    = dispatch_slots;
  endtask

  initial begin
    lfsr           = 32'hb601_2823;
    reset          = 1'b1;
    dispatch_free  = 2'd0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    wb_ack         = 1'b0;
    wb_dat_i       = '0;
    errors         = 0;
    accepted       = 0;
    bus_reads      = 0;
    exp_pc         = `FE_RESET_PC;
    exp_status     = isa_pkg::NO_ERROR;
    prev_hold      = 1'b0;
    prev_redirect  = 1'b0;
    in_transfer    = 1'b0;
    wait_left      = 2'd0;
    for (int i = 0; i < 256; i++) mem[i] = make_word();
    for (int i = 0; i < `FE_CACHE_LINES; i++) tag_valid[i] = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    if (wb_req.cyc || dispatch_slots[0].valid || dispatch_slots[1].valid) begin
      errors++;
      $display("Bus request or dispatch slot active right after reset");
    end
    repeat (RUN_CYCLES) begin
      @(negedge clock);
      step_cycle();
    end
    if (accepted == 0) begin
      errors++;
      $display("No instruction was dispatched during the run");
    end
    $display("Run done: %0d errors, %0d instructions checked, %0d bus reads",
             errors, accepted, bus_reads);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
